//--- design/viterbi_code_pkg.sv
`default_nettype none

package viterbi_code_pkg;

    //////////////////////////////////////////////////
    // Rate 1/2, K=3 convolutional code (7,5 octal)
    //////////////////////////////////////////////////

    localparam int CONSTRAINT_LEN = 3;                  // K
    localparam int STATE_W        = CONSTRAINT_LEN - 1; // Encoder memory in bits
    localparam int NUM_STATES     = 1 << STATE_W;       // Trellis states

    // Generator taps, MSB taps the incoming bit
    localparam logic [CONSTRAINT_LEN-1:0] GEN_0 = 3'b111; // Octal 7
    localparam logic [CONSTRAINT_LEN-1:0] GEN_1 = 3'b101; // Octal 5

    typedef logic [STATE_W-1:0] state_t;  // {newest bit, older bit}
    typedef logic [1:0]         symbol_t; // {GEN_0 parity, GEN_1 parity}

    //////////////////////////////////////////////////
    // Encoder trellis
    //////////////////////////////////////////////////

    // Code symbol emitted when bit u enters the encoder in state s
    function automatic symbol_t code_symbol(state_t s, logic u);
        logic [CONSTRAINT_LEN-1:0] shreg;
        shreg = {u, s};                                  // Newest bit on top
        return {^(shreg & GEN_0), ^(shreg & GEN_1)};
    endfunction

    // Predecessor of state s, d picks the bit that fell out of the register
    function automatic state_t prev_state(state_t s, logic d);
        return {s[STATE_W-2:0], d};                      // Old lower bit moves up
    endfunction

endpackage

`default_nettype wire

//--- design/viterbi_dec_pkg.sv
`default_nettype none

package viterbi_dec_pkg;

    //////////////////////////////////////////////////
    // Decoder architecture
    //////////////////////////////////////////////////

    localparam int METRIC_W    = 6;  // Path metric width, normalized every symbol
    localparam int BM_W        = 2;  // Hamming distance 0..2
    localparam int TB_DEPTH    = 15; // Survivor ring depth in symbols
    localparam int PTR_W       = 4;  // Ring pointer, also holds TB_DEPTH itself
    localparam int INIT_METRIC = 16; // Start penalty for all states but 0

    // Distance of the received symbol to each code symbol value
    typedef struct packed {
        logic [BM_W-1:0] bm_11;
        logic [BM_W-1:0] bm_10;
        logic [BM_W-1:0] bm_01;
        logic [BM_W-1:0] bm_00;
    } branch_metrics_t;

    // One bit per state, the lower bit of the surviving predecessor
    typedef struct packed {
        logic dec_s3;
        logic dec_s2;
        logic dec_s1;
        logic dec_s0;
    } decision_t;

    // Accumulated metric per state
    typedef struct packed {
        logic [METRIC_W-1:0] pm_s3;
        logic [METRIC_W-1:0] pm_s2;
        logic [METRIC_W-1:0] pm_s1;
        logic [METRIC_W-1:0] pm_s0;
    } path_metrics_t;

endpackage

`default_nettype wire

//--- design/branch_metric_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_metric_unit (
    input  wire viterbi_code_pkg::symbol_t    sym, // Received hard-decision symbol
    output viterbi_dec_pkg::branch_metrics_t  bm   // Distance to every code symbol
);

    //////////////////////////////////////////////////
    // Hamming distance
    //////////////////////////////////////////////////

    // Popcount of the differing bits
    function automatic logic [viterbi_dec_pkg::BM_W-1:0] hamming(
        viterbi_code_pkg::symbol_t rx,
        viterbi_code_pkg::symbol_t code
    );
        viterbi_code_pkg::symbol_t diff;
        diff = rx ^ code;
        return {1'b0, diff[1]} + {1'b0, diff[0]};
    endfunction

    // One field per code symbol value
    always_comb begin
        bm.bm_00 = hamming(sym, 2'b00);
        bm.bm_01 = hamming(sym, 2'b01);
        bm.bm_10 = hamming(sym, 2'b10);
        bm.bm_11 = hamming(sym, 2'b11); // Two minus bm_00
    end

endmodule

`default_nettype wire

//--- design/acs_unit.sv
`timescale 1ns/1ps
`default_nettype none

module acs_unit (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire viterbi_dec_pkg::branch_metrics_t bm,         // From branch metric unit
    output viterbi_dec_pkg::decision_t            decisions,  // Survivor choice per state
    output viterbi_code_pkg::state_t              best_state  // Lowest registered metric
);

    viterbi_dec_pkg::path_metrics_t pm_q; // Metrics after the previous symbol

    // Indexable views of the structs
    logic [viterbi_code_pkg::NUM_STATES-1:0][viterbi_dec_pkg::METRIC_W-1:0] pm_old;
    logic [viterbi_code_pkg::NUM_STATES-1:0][viterbi_dec_pkg::METRIC_W-1:0] pm_new;
    logic [viterbi_code_pkg::NUM_STATES-1:0][viterbi_dec_pkg::METRIC_W-1:0] pm_norm;
    logic [3:0][viterbi_dec_pkg::BM_W-1:0]                                  bm_arr;
    logic [viterbi_code_pkg::NUM_STATES-1:0]                                dec;
    logic [viterbi_dec_pkg::METRIC_W-1:0]                                   min_new;

    assign pm_old = pm_q;
    assign bm_arr = bm; // Entry n holds the distance to code symbol n

    //////////////////////////////////////////////////
    // Add-compare-select
    //////////////////////////////////////////////////
    always_comb begin
        viterbi_code_pkg::state_t             tgt;
        viterbi_code_pkg::state_t             p0;
        viterbi_code_pkg::state_t             p1;
        viterbi_code_pkg::symbol_t            c0;
        viterbi_code_pkg::symbol_t            c1;
        logic [viterbi_dec_pkg::METRIC_W-1:0] cand0;
        logic [viterbi_dec_pkg::METRIC_W-1:0] cand1;
        for (int t = 0; t < viterbi_code_pkg::NUM_STATES; t++) begin
            tgt = viterbi_code_pkg::state_t'(t);
            p0  = viterbi_code_pkg::prev_state(tgt, 1'b0);
            p1  = viterbi_code_pkg::prev_state(tgt, 1'b1);
            // Both branches carry the new bit, the upper bit of the target
            c0  = viterbi_code_pkg::code_symbol(p0, tgt[viterbi_code_pkg::STATE_W-1]);
            c1  = viterbi_code_pkg::code_symbol(p1, tgt[viterbi_code_pkg::STATE_W-1]);
            cand0 = pm_old[p0] + viterbi_dec_pkg::METRIC_W'(bm_arr[c0]);
            cand1 = pm_old[p1] + viterbi_dec_pkg::METRIC_W'(bm_arr[c1]);
            dec[t]    = (cand1 < cand0);           // Lower predecessor wins a tie
            pm_new[t] = dec[t] ? cand1 : cand0;
        end
    end

    // Normalize so the smallest metric becomes zero
    always_comb begin
        min_new = pm_new[0];
        for (int s = 1; s < viterbi_code_pkg::NUM_STATES; s++) begin
            if (pm_new[s] < min_new) begin
                min_new = pm_new[s];
            end
        end
        for (int s = 0; s < viterbi_code_pkg::NUM_STATES; s++) begin
            pm_norm[s] = pm_new[s] - min_new;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pm_q <= '{
                pm_s3: viterbi_dec_pkg::METRIC_W'(viterbi_dec_pkg::INIT_METRIC),
                pm_s2: viterbi_dec_pkg::METRIC_W'(viterbi_dec_pkg::INIT_METRIC),
                pm_s1: viterbi_dec_pkg::METRIC_W'(viterbi_dec_pkg::INIT_METRIC),
                pm_s0: '0                                // Encoder starts in state 0
            };
        end else begin
            pm_q <= pm_norm;
        end
    end

    //////////////////////////////////////////////////
    // Best state from the registered metrics
    //////////////////////////////////////////////////
    always_comb begin
        logic [viterbi_dec_pkg::METRIC_W-1:0] best_m;
        best_m     = pm_old[0];
        best_state = '0;
        for (int s = 1; s < viterbi_code_pkg::NUM_STATES; s++) begin
            if (pm_old[s] < best_m) begin          // Strict, lowest index keeps a tie
                best_m     = pm_old[s];
                best_state = viterbi_code_pkg::state_t'(s);
            end
        end
    end

    assign decisions = dec;

endmodule

`default_nettype wire

//--- design/survivor_mem.sv
`timescale 1ns/1ps
`default_nettype none

module survivor_mem (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire [viterbi_dec_pkg::PTR_W-1:0]         wr_ptr,    // Slot of the current symbol
    input  wire viterbi_dec_pkg::decision_t          decisions, // ACS decisions, this symbol
    output viterbi_dec_pkg::decision_t [viterbi_dec_pkg::TB_DEPTH-1:0] window // Whole ring
);

    //////////////////////////////////////////////////
    // Decision ring
    //////////////////////////////////////////////////

    // Slot i holds the decisions of the last symbol k with k mod TB_DEPTH == i
    viterbi_dec_pkg::decision_t [viterbi_dec_pkg::TB_DEPTH-1:0] ring;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ring <= '0;
        end else begin
            // Decoded write enable, one slot per cycle
            for (int i = 0; i < viterbi_dec_pkg::TB_DEPTH; i++) begin
                if (wr_ptr == viterbi_dec_pkg::PTR_W'(i)) begin
                    ring[i] <= decisions; // Oldest entry, no longer traced
                end
            end
        end
    end

    // Traceback sees the ring as it stood before the edge
    assign window = ring;

endmodule

`default_nettype wire

//--- design/traceback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module traceback_unit (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire viterbi_dec_pkg::decision_t [viterbi_dec_pkg::TB_DEPTH-1:0] window,
    input  wire [viterbi_dec_pkg::PTR_W-1:0]     wr_ptr,     // Slot of symbol k
    input  wire viterbi_code_pkg::state_t        best_state, // State after symbol k-1
    input  wire                                  tb_go,      // Window holds a full history
    output logic                                 bit_out,    // Decoded bit of symbol k-15
    output logic                                 bit_valid
);

    logic newest_is_top;                             // Pointer sits at slot 0
    logic [viterbi_dec_pkg::PTR_W-1:0] newest_slot;  // Decisions of symbol k-1
    logic tb_bit;

    assign newest_is_top = (wr_ptr == '0);
    assign newest_slot   = newest_is_top ? viterbi_dec_pkg::PTR_W'(viterbi_dec_pkg::TB_DEPTH - 1)
                                         : wr_ptr - viterbi_dec_pkg::PTR_W'(1);

    //////////////////////////////////////////////////
    // Full traceback every cycle
    //////////////////////////////////////////////////
    always_comb begin
        viterbi_code_pkg::state_t                st;
        logic [viterbi_dec_pkg::PTR_W-1:0]       slot;
        logic [viterbi_code_pkg::NUM_STATES-1:0] dec_bits;
        st   = best_state;
        slot = newest_slot;
        // Symbols k-1 down to k-14
        for (int i = 0; i < viterbi_dec_pkg::TB_DEPTH - 1; i++) begin
            dec_bits = window[slot];
            st = viterbi_code_pkg::prev_state(st, dec_bits[st]);
            if (slot == '0) begin                    // Wrap backwards
                slot = viterbi_dec_pkg::PTR_W'(viterbi_dec_pkg::TB_DEPTH - 1);
            end else begin
                slot = slot - viterbi_dec_pkg::PTR_W'(1);
            end
        end
        tb_bit = st[viterbi_code_pkg::STATE_W-1];    // Input bit that led into st
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (tb_go) begin
            bit_out <= tb_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_valid <= 1'b0;
        end else begin
            bit_valid <= tb_go;      // Level, stays high once the ring has filled
        end
    end

endmodule

`default_nettype wire

//--- design/viterbi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_ctrl (
    input  wire                               clk,
    input  wire                               rst_n,
    output logic [viterbi_dec_pkg::PTR_W-1:0] wr_ptr, // Ring slot of the current symbol
    output logic                              tb_go   // Traceback window is complete
);

    //////////////////////////////////////////////////
    // Symbol sequencing
    //////////////////////////////////////////////////

    logic [viterbi_dec_pkg::PTR_W-1:0] fill_cnt; // Symbols seen since reset, saturates
    logic                              ptr_wrap;

    assign ptr_wrap = (wr_ptr == viterbi_dec_pkg::PTR_W'(viterbi_dec_pkg::TB_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            fill_cnt <= '0;
        end else begin
            // One symbol per clock, no stalls
            if (ptr_wrap) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + viterbi_dec_pkg::PTR_W'(1);
            end
            if (!tb_go) begin
                fill_cnt <= fill_cnt + viterbi_dec_pkg::PTR_W'(1); // Stops at TB_DEPTH
            end
        end
    end

    // High in cycle k for every k >= TB_DEPTH
    assign tb_go = (fill_cnt == viterbi_dec_pkg::PTR_W'(viterbi_dec_pkg::TB_DEPTH));

endmodule

`default_nettype wire

//--- design/viterbi_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_decoder (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire viterbi_code_pkg::symbol_t sym,       // One received symbol per clock
    output logic                           bit_out,   // Decoded bit, 16 cycles behind sym
    output logic                           bit_valid
);

    //////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////

    logic [viterbi_dec_pkg::PTR_W-1:0]                          wr_ptr;
    logic                                                       tb_go;
    viterbi_dec_pkg::branch_metrics_t                           bm;
    viterbi_dec_pkg::decision_t                                 decisions;
    viterbi_code_pkg::state_t                                   best_state;
    viterbi_dec_pkg::decision_t [viterbi_dec_pkg::TB_DEPTH-1:0] window;

    // Control
    viterbi_ctrl u_viterbi_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_ptr (wr_ptr),
        .tb_go  (tb_go)
    );

    // Datapath
    branch_metric_unit u_branch_metric_unit (
        .sym (sym),
        .bm  (bm)
    );

    acs_unit u_acs_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .bm         (bm),
        .decisions  (decisions),
        .best_state (best_state)
    );

    survivor_mem u_survivor_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_ptr    (wr_ptr),
        .decisions (decisions),
        .window    (window)
    );

    traceback_unit u_traceback_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .window     (window),
        .wr_ptr     (wr_ptr),
        .best_state (best_state),
        .tb_go      (tb_go),
        .bit_out    (bit_out),
        .bit_valid  (bit_valid)
    );

endmodule

`default_nettype wire

//--- verification/viterbi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_tb;

    //////////////////////////////////////////////////
    // Test lengths and timing
    //////////////////////////////////////////////////

    localparam int CLK_PERIOD  = 8;
    localparam int LATENCY     = 16;  // Symbol n decodes in cycle n+16
    localparam int FLUSH_LEN   = 17;  // Enough to push the last source bit out
    localparam int BLOCK_LEN   = 24;  // One flipped symbol bit per block
    localparam int RAND_LEN    = 1000;
    localparam int RUN_LEN     = 2000;
    localparam int MID_LEN     = 500;
    localparam int RESTART_LEN = 300;
    localparam int TOTAL_SYMS  = 2 * RAND_LEN + 2 * RUN_LEN + MID_LEN + RESTART_LEN
                               + 4 * FLUSH_LEN;
    localparam int RESET_CYCLES = 5 * 4;                       // Five resets of 4 cycles
    localparam int WATCHDOG_NS  = (TOTAL_SYMS + RESET_CYCLES + 100) * CLK_PERIOD;

    logic                      clk;
    logic                      rst_n;
    viterbi_code_pkg::symbol_t sym;
    logic                      bit_out;
    logic                      bit_valid;

    viterbi_code_pkg::state_t  enc_state;   // Reference encoder state
    logic [31:0]               rng;         // Xorshift state
    logic                      exp_q[$];    // Source bits awaiting their decoded copy
    logic                      exp_bit;
    int                        checked_cnt; // Decoded bits compared since last reset
    int                        cyc;         // Cycle index since reset release
    logic                      in_reset;

    viterbi_decoder u_viterbi_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .sym       (sym),
        .bit_out   (bit_out),
        .bit_valid (bit_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Reference models
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Rate 1/2 encoder, state holds {newest bit, older bit}
    function automatic viterbi_code_pkg::symbol_t conv_encode(
        input  viterbi_code_pkg::state_t st,
        input  logic                     u,
        output viterbi_code_pkg::state_t nxt
    );
        logic p_hi;
        logic p_lo;
        p_hi = u ^ st[1] ^ st[0]; // Taps 111
        p_lo = u ^ st[0];         // Taps 101, skips the newer state bit
        nxt  = {u, st[1]};        // New bit enters at the top
        return {p_hi, p_lo};
    endfunction

    //////////////////////////////////////////////////
    // Failure handling and watchdog
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the tests did not finish in %0d ns", WATCHDOG_NS);
        abort_run();
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Four cycles low, released together with the first symbol
    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        sym   = '0;
        repeat (3) @(posedge clk);
        enc_state   = '0;
        exp_q.delete();
        checked_cnt = 0;
    endtask

    task automatic drive_bit(input logic u, input logic [1:0] flip);
        viterbi_code_pkg::symbol_t code;
        viterbi_code_pkg::state_t  nxt;
        code = conv_encode(enc_state, u, nxt);
        @(posedge clk);
        #1;
        rst_n     = 1'b1;
        sym       = code ^ flip; // Channel error where flip is set
        enc_state = nxt;
        exp_q.push_back(u);
    endtask

    task automatic send_random(input int n, input logic inject);
        int         flip_sym;
        int         flip_bit;
        logic [1:0] flip;
        logic       u;
        flip_sym = -1;
        flip_bit = 0;
        for (int i = 0; i < n; i++) begin
            if (inject && (i % BLOCK_LEN == 0)) begin
                rng      = xorshift32(rng);
                flip_sym = int'(rng % 32'd48) / 2; // Symbol inside the block
                flip_bit = int'(rng % 32'd48) % 2;
            end
            flip = '0;
            if (inject && (i % BLOCK_LEN == flip_sym)) begin
                flip = (flip_bit == 1) ? 2'b01 : 2'b10;
            end
            rng = xorshift32(rng);
            u   = rng[16];
            drive_bit(u, flip);
        end
    endtask

    task automatic send_const(input int n, input logic u);
        repeat (n) drive_bit(u, 2'b00);
    endtask

    // Zero tail, then every source bit must have been compared
    task automatic finish_stream(input int n);
        repeat (FLUSH_LEN) drive_bit(1'b0, 2'b00);
        assert (checked_cnt >= n) else begin
            $display("Only %0d of %0d decoded bits were compared", checked_cnt, n);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Comparator, samples mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            if (in_reset) begin
                assert (bit_valid === 1'b0) else begin // Cleared by the reset edge
                    $display("** Error @ %0t: bit_valid = %b, expected 0", $time, bit_valid);
                    abort_run();
                end
            end
            in_reset = 1'b1;
            cyc      = 0;
        end else begin
            in_reset = 1'b0;
            assert (bit_valid === (cyc >= LATENCY)) else begin
                $display("** Error @ %0t: bit_valid = %b, expected %b (cycle %0d)",
                         $time, bit_valid, (cyc >= LATENCY), cyc);
                abort_run();
            end
            if (bit_valid === 1'b1) begin
                assert (exp_q.size() > 0) else begin
                    $display("bit_valid is high but no source bit is outstanding");
                    abort_run();
                end
                exp_bit = exp_q.pop_front(); // Oldest symbol still in flight
                assert (bit_out === exp_bit) else begin
                    $display("** Error @ %0t: bit_out = %b, expected %b (bit %0d)",
                             $time, bit_out, exp_bit, checked_cnt);
                    abort_run();
                end
                checked_cnt++;
            end
            cyc++;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        sym         = '0;
        enc_state   = '0;
        rng         = 32'h978f1ead;
        checked_cnt = 0;
        cyc         = 0;
        in_reset    = 1'b0;

        // Latency and clean random stream
        apply_reset();
        send_random(RAND_LEN, 1'b0);
        finish_stream(RAND_LEN);

        // One channel error per block
        apply_reset();
        send_random(RAND_LEN, 1'b1);
        finish_stream(RAND_LEN);

        // Long constant runs exercise metric normalization
        apply_reset();
        send_const(RUN_LEN, 1'b0);
        send_const(RUN_LEN, 1'b1);
        finish_stream(2 * RUN_LEN);

        // Reset in the middle of a stream, last symbol is still in its own cycle
        apply_reset();
        send_random(MID_LEN, 1'b0);
        assert (checked_cnt >= MID_LEN - LATENCY - 1) else begin
            $display("Too few bits decoded before the mid-stream reset: %0d", checked_cnt);
            abort_run();
        end
        apply_reset();
        send_random(RESTART_LEN, 1'b0);
        finish_stream(RESTART_LEN);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
design/viterbi_code_pkg.sv
design/viterbi_dec_pkg.sv
design/branch_metric_unit.sv
design/acs_unit.sv
design/survivor_mem.sv
design/traceback_unit.sv
design/viterbi_ctrl.sv
design/viterbi_decoder.sv
verification/viterbi_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Viterbi decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module viterbi_tb -o viterbi_sim

# Exit status of the pipe is the one of tee, the log decides the result
./obj_dir/viterbi_sim 2>&1 | tee "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
